// File: Makefile
BIN := obj_dir/Vtb_i2c_init
SRCS := $(shell cat flist.f)

.PHONY: all run clean

all: $(BIN)

$(BIN): flist.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_i2c_init -f flist.f

run: $(BIN)
	$(BIN) | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

// File: flist.f
source/i2c_init_pkg.sv
source/init_table_rom.sv
source/init_sequencer.sv
source/i2c_cmd_out.sv
source/i2c_init.sv
sim/tb_i2c_init.sv

// File: sim/tb_i2c_init.sv
// testbench for the I2C init sequencer top level
// builds the expected command and data beats from the table file, then runs
// the table twice under random ready stalls and scores every transfer
// run from the project root so the table file path resolves

`timescale 1ns/1ps
`default_nettype none

module tb_i2c_init
    import i2c_init_pkg::*;
();

    logic      clk;
    logic      rst;
    logic      start;
    logic      cmd_ready = 1'b0;
    logic      data_tready = 1'b0;
    dev_addr_t cmd_address;
    logic      cmd_start, cmd_write, cmd_stop, cmd_valid;
    byte_t     data_tdata;
    logic      data_tvalid;
    logic      busy;
    logic [9:0] cmd_beat;

    // expected beats, a command packed as {address, start, write, stop}
    logic [9:0] exp_cmd[$];
    byte_t      exp_data[$];
    bit         cmd_multi[$];
    bit         data_multi[$];
    entry_t     table_mem [0:INIT_LEN-1];

    // monitor state, 1 = first run, 2 = rerun after start toggles
    int         phase = 0;
    int         seen_phase = 0;
    int         cmd_idx = 0;
    int         data_idx = 0;
    int         err_single = 0;
    int         err_multi = 0;
    int         err_back = 0;
    int         err_rerun = 0;
    bit         busy_seen = 1'b0;
    bit         cmd_stall = 1'b0;
    bit         data_stall = 1'b0;
    logic [9:0] cmd_held;
    byte_t      data_held;

    // main process bookkeeping
    int err_reset = 0;
    int err_counts = 0;
    int err_start = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int total_errors = 0;
    bit timed_out = 1'b0;

    assign cmd_beat = {cmd_address, cmd_start, cmd_write, cmd_stop};

    i2c_init dut_i (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .cmd_address (cmd_address),
        .cmd_start   (cmd_start),
        .cmd_write   (cmd_write),
        .cmd_stop    (cmd_stop),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .data_tdata  (data_tdata),
        .data_tvalid (data_tvalid),
        .data_tready (data_tready),
        .busy        (busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // random stalls on both channels, independent of each other
    always @(negedge clk) begin
        if (!rst) begin
            cmd_ready   = ($urandom % 100) < 60;
            data_tready = ($urandom % 100) < 60;
        end
    end

    // walk the table file by the entry rules and queue the expected beats
    task automatic build_model();
        seq_state_t mode = SEQ_RUN;
        int         idx = 0;
        int         next = 0;
        int         data_ptr = 0;
        int         addr_ptr = 0;
        int         steps = 0;
        dev_addr_t  addr_q = '0;
        bit         start_q = 1'b0;
        bit         done = 1'b0;
        entry_t     e;
        $readmemh(INIT_FILE, table_mem);
        while (!done && steps < 16 * INIT_LEN) begin
            e = table_mem[idx];
            next = (idx + 1) % INIT_LEN;
            steps++;
            if (e == OP_END) begin
                exp_cmd.push_back({addr_q, 3'b001});
                cmd_multi.push_back(mode != SEQ_RUN);
                done = 1'b1;
            end else if (e == OP_DATA_BLOCK) begin
                data_ptr = next;
                mode = SEQ_FIND_ADDR_BLOCK;
            end else if (e == OP_EXIT_MULTI) begin
                mode = SEQ_RUN;
            end else if (mode == SEQ_RUN || mode == SEQ_DATA_BLOCK) begin
                if (e[8]) begin
                    exp_cmd.push_back({addr_q, start_q, 2'b10});
                    cmd_multi.push_back(mode != SEQ_RUN);
                    exp_data.push_back(e[7:0]);
                    data_multi.push_back(mode != SEQ_RUN);
                    start_q = 1'b0;
                end else if (e[8:7] == 2'b01) begin
                    addr_q = e[6:0];
                    start_q = 1'b1;
                end else if (e == OP_SEND_STOP) begin
                    exp_cmd.push_back({addr_q, 3'b001});
                    cmd_multi.push_back(mode != SEQ_RUN);
                    start_q = 1'b0;
                end else if (mode == SEQ_DATA_BLOCK && e == OP_WRITE_CUR) begin
                    start_q = 1'b1;
                    addr_q = table_mem[addr_ptr - 1][6:0];
                end else if (mode == SEQ_DATA_BLOCK && e == OP_ADDR_BLOCK) begin
                    next = addr_ptr;
                    mode = SEQ_NEXT_ADDR;
                end
            end else if (mode == SEQ_FIND_ADDR_BLOCK && e == OP_ADDR_BLOCK) begin
                addr_ptr = next;
                mode = SEQ_NEXT_ADDR;
            end else if (mode == SEQ_NEXT_ADDR && e[8:7] == 2'b01) begin
                // one pass of the data block per listed device
                addr_ptr = next;
                next = data_ptr;
                mode = SEQ_DATA_BLOCK;
            end
            idx = next;
        end
    endtask

    task automatic record_beat_error(input bit multi);
        if (phase == 2) begin
            err_rerun++;
        end else if (multi) begin
            err_multi++;
        end else begin
            err_single++;
        end
    endtask

    function automatic string beat_test(input bit multi);
        if (phase == 2) begin
            return "start_control";
        end
        return multi ? "multi_device" : "single_device";
    endfunction

    // scoreboard and stall checks, sampled before the DUT registers update
    always @(posedge clk) begin
        if (!rst) begin
            if (phase != seen_phase) begin
                seen_phase = phase;
                cmd_idx = 0;
                data_idx = 0;
            end
            if (cmd_stall) begin
                assert (cmd_valid && cmd_beat == cmd_held) else begin
                    $display("FAIL back_pressure: expected cmd %h, actual %h valid %b",
                             cmd_held, cmd_beat, cmd_valid);
                    err_back++;
                end
            end
            if (data_stall) begin
                assert (data_tvalid && data_tdata == data_held) else begin
                    $display("FAIL back_pressure: expected data %h, actual %h valid %b",
                             data_held, data_tdata, data_tvalid);
                    err_back++;
                end
            end
            if (cmd_valid && cmd_ready) begin
                if (cmd_idx < exp_cmd.size()) begin
                    assert (cmd_beat == exp_cmd[cmd_idx]) else begin
                        $display("FAIL %s: cmd beat %0d expected %h, actual %h",
                                 beat_test(cmd_multi[cmd_idx]), cmd_idx,
                                 exp_cmd[cmd_idx], cmd_beat);
                        record_beat_error(cmd_multi[cmd_idx]);
                    end
                end
                cmd_idx++;
            end
            if (data_tvalid && data_tready) begin
                if (data_idx < exp_data.size()) begin
                    assert (data_tdata == exp_data[data_idx]) else begin
                        $display("FAIL %s: data byte %0d expected %h, actual %h",
                                 beat_test(data_multi[data_idx]), data_idx,
                                 exp_data[data_idx], data_tdata);
                        record_beat_error(data_multi[data_idx]);
                    end
                end
                data_idx++;
            end
            if (phase == 2 && busy) begin
                busy_seen = 1'b1;
            end
            cmd_stall = cmd_valid && !cmd_ready;
            data_stall = data_tvalid && !data_tready;
            cmd_held = cmd_beat;
            data_held = data_tdata;
        end
    end

    task automatic wait_beats(input string name, inout int errs);
        int cycles = 0;
        while ((cmd_idx < exp_cmd.size() || data_idx < exp_data.size()) && cycles < 5000) begin
            @(negedge clk);
            cycles++;
        end
        if (cmd_idx < exp_cmd.size() || data_idx < exp_data.size()) begin
            $display("%s: timed out waiting for the expected beats", name);
            errs++;
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_busy_low(inout int errs);
        int cycles = 0;
        while (busy && cycles < 50) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            $display("start_control: busy still high long after the final stop");
            errs++;
            timed_out = 1'b1;
        end
    endtask

    // beat totals after a quiet stretch, catches lost and extra beats
    task automatic check_counts(input string name, inout int errs);
        repeat (30) @(negedge clk);
        assert (cmd_idx == exp_cmd.size() && data_idx == exp_data.size()) else begin
            $display("FAIL %s: expected %0d cmd / %0d data beats, actual %0d / %0d",
                     name, exp_cmd.size(), exp_data.size(), cmd_idx, data_idx);
            errs++;
        end
    endtask

    task automatic report_test(input string name, input int errs);
        tests_run++;
        total_errors += errs;
        if (errs == 0) begin
            $display("test %-14s ok", name);
        end else begin
            tests_failed++;
            $display("test %-14s failed with %0d errors", name, errs);
        end
    endtask

    initial begin
        rst = 1'b1;
        start = 1'b0;
        void'($urandom(25733));
        build_model();
        repeat (3) @(negedge clk);
        rst = 1'b0;

        // idle outputs before any start
        repeat (8) begin
            @(negedge clk);
            assert (!cmd_valid && !data_tvalid && !busy) else begin
                $display("FAIL reset_state: expected valid/tvalid/busy 000, actual %b%b%b",
                         cmd_valid, data_tvalid, busy);
                err_reset++;
            end
        end
        report_test("reset_state", err_reset);

        phase = 1;
        @(negedge clk);
        start = 1'b1;
        wait_beats("single_device", err_single);
        check_counts("back_pressure", err_counts);
        report_test("single_device", err_single);
        report_test("multi_device", err_multi);
        report_test("back_pressure", err_back + err_counts);

        // start stays high, nothing may restart
        repeat (40) begin
            @(negedge clk);
            assert (!cmd_valid && !data_tvalid && !busy) else begin
                $display("start_control: new activity while start is held high");
                err_start++;
            end
        end
        phase = 2;
        start = 1'b0;
        repeat (4) @(negedge clk);
        start = 1'b1;
        wait_beats("start_control", err_start);
        wait_busy_low(err_start);
        check_counts("start_control", err_start);
        assert (busy_seen) else begin
            $display("start_control: busy never went high during the second run");
            err_start++;
        end
        report_test("start_control", err_start + err_rerun);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (tests_failed == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/i2c_cmd_out.sv
// output registers toward the I2C master
// takes one-cycle requests from the sequencer and holds the command and data
// beats until each is accepted, the two channels drain independently
// pending tells the sequencer that a beat is still outstanding

`timescale 1ns/1ps
`default_nettype none

module i2c_cmd_out
    import i2c_init_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  emit_t     emit,
    input  dev_addr_t emit_addr,
    input  byte_t     emit_data,
    output logic      pending,
    output dev_addr_t cmd_address,
    output logic      cmd_start,
    output logic      cmd_write,
    output logic      cmd_stop,
    output logic      cmd_valid,
    input  logic      cmd_ready,
    output byte_t     data_tdata,
    output logic      data_tvalid,
    input  logic      data_tready
);

    logic cmd_xfer;
    logic data_xfer;

    assign cmd_xfer  = cmd_valid && cmd_ready;
    assign data_xfer = data_tvalid && data_tready;

    assign pending = cmd_valid || data_tvalid;

    // control flags and valids
    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_start   <= 1'b0;
            cmd_write   <= 1'b0;
            cmd_stop    <= 1'b0;
            cmd_valid   <= 1'b0;
            data_tvalid <= 1'b0;
        end else begin
            // accepted command clears every flag
            if (cmd_xfer) begin
                cmd_start <= 1'b0;
                cmd_write <= 1'b0;
                cmd_stop  <= 1'b0;
                cmd_valid <= 1'b0;
            end
            if (data_xfer) begin
                data_tvalid <= 1'b0;
            end
            case (emit)
                EMIT_ADDR: begin
                    // start sticks until the next write goes out
                    cmd_start <= 1'b1;
                end
                EMIT_WRITE: begin
                    cmd_write   <= 1'b1;
                    cmd_stop    <= 1'b0;
                    cmd_valid   <= 1'b1;
                    data_tvalid <= 1'b1;
                end
                EMIT_STOP: begin
                    cmd_start <= 1'b0;
                    cmd_write <= 1'b0;
                    cmd_stop  <= 1'b1;
                    cmd_valid <= 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (emit == EMIT_ADDR) begin
            cmd_address <= emit_addr;
        end
        if (emit == EMIT_WRITE) begin
            data_tdata <= emit_data;
        end
    end

    // a stalled beat keeps its payload and its valid
    assert property (@(posedge clk) disable iff (rst)
        (cmd_valid && !cmd_ready) |=>
            cmd_valid && $stable({cmd_address, cmd_start, cmd_write, cmd_stop}));

    assert property (@(posedge clk) disable iff (rst)
        (data_tvalid && !data_tready) |=> data_tvalid && $stable(data_tdata));

endmodule

`default_nettype wire

// File: source/i2c_init.sv
// I2C power-on init sequencer, top level
// walks the command table and feeds an I2C master over two valid/ready
// streams, one for commands and one for write data
// raise start to run the table once, busy is high while it runs

`timescale 1ns/1ps
`default_nettype none

module i2c_init
    import i2c_init_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    output dev_addr_t cmd_address,
    output logic      cmd_start,
    output logic      cmd_write,
    output logic      cmd_stop,
    output logic      cmd_valid,
    input  logic      cmd_ready,
    output byte_t     data_tdata,
    output logic      data_tvalid,
    input  logic      data_tready,
    output logic      busy
);

    // table read path
    rom_addr_t rd_addr;
    entry_t    entry;

    // request path to the output registers
    emit_t     emit;
    dev_addr_t emit_addr;
    byte_t     emit_data;
    logic      pending;

    init_table_rom rom_i (
        .clk     (clk),
        .rd_addr (rd_addr),
        .entry   (entry)
    );

    init_sequencer seq_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .entry     (entry),
        .pending   (pending),
        .rd_addr   (rd_addr),
        .emit      (emit),
        .emit_addr (emit_addr),
        .emit_data (emit_data),
        .busy      (busy)
    );

    i2c_cmd_out out_i (
        .clk         (clk),
        .rst         (rst),
        .emit        (emit),
        .emit_addr   (emit_addr),
        .emit_data   (emit_data),
        .pending     (pending),
        .cmd_address (cmd_address),
        .cmd_start   (cmd_start),
        .cmd_write   (cmd_write),
        .cmd_stop    (cmd_stop),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .data_tdata  (data_tdata),
        .data_tvalid (data_tvalid),
        .data_tready (data_tready)
    );

endmodule

`default_nettype wire

// File: source/i2c_init_pkg.sv
// shared widths, table opcodes and state encodings for the I2C init sequencer
// imported by the ROM, the sequencer, the output stage and the testbench model
// the command table itself lives in the hex file named by INIT_FILE

`default_nettype none

package i2c_init_pkg;

    // table geometry
    localparam int INIT_LEN    = 32;
    localparam int INIT_ADDR_W = 5;

    // relative to the simulation run directory
    localparam string INIT_FILE = "source/init_table.mem";

    typedef logic [8:0]             entry_t;
    typedef logic [6:0]             dev_addr_t;
    typedef logic [7:0]             byte_t;
    typedef logic [INIT_ADDR_W-1:0] rom_addr_t;

    // opcodes with the two top bits clear
    // 1dddddddd writes a data byte, 01aaaaaaa starts a write to address a
    localparam entry_t OP_END        = 9'h000;
    localparam entry_t OP_EXIT_MULTI = 9'h001;
    localparam entry_t OP_WRITE_CUR  = 9'h003;
    localparam entry_t OP_ADDR_BLOCK = 9'h008;
    localparam entry_t OP_DATA_BLOCK = 9'h009;
    localparam entry_t OP_SEND_STOP  = 9'h041;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_RUN,
        SEQ_FIND_ADDR_BLOCK,
        SEQ_NEXT_ADDR,
        SEQ_DATA_BLOCK
    } seq_state_t;

    // one-cycle request from the sequencer to the output registers
    typedef enum logic [1:0] {
        EMIT_NONE,
        EMIT_ADDR,
        EMIT_WRITE,
        EMIT_STOP
    } emit_t;

endpackage

`default_nettype wire

// File: source/init_sequencer.sv
// table walker for the I2C init sequence
// reads one entry per cycle from the ROM and turns it into output requests
// single-device entries pass straight through, a data block is replayed once
// for every address in the following address block
// a rising start level begins a run, busy follows the FSM one cycle late

`timescale 1ns/1ps
`default_nettype none

module init_sequencer
    import i2c_init_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  entry_t    entry,
    input  logic      pending,
    output rom_addr_t rd_addr,
    output emit_t     emit,
    output dev_addr_t emit_addr,
    output byte_t     emit_data,
    output logic      busy
);

    seq_state_t state_reg, state_next;

    // entry index, entry register holds table[idx_reg]
    rom_addr_t idx_reg, idx_next;
    rom_addr_t idx_inc;

    // first entry of the data block and next entry of the address block
    rom_addr_t data_ptr_reg, data_ptr_next;
    rom_addr_t addr_ptr_reg, addr_ptr_next;

    // device address substituted for write-current inside a data block
    dev_addr_t cur_addr_reg, cur_addr_next;

    logic start_flag_reg, start_flag_next;
    logic use_cur;

    assign idx_inc = idx_reg + 1'b1;

    // ROM is addressed with the next index so entry lines up with idx_reg
    assign rd_addr = idx_next;

    assign emit_addr = use_cur ? cur_addr_reg : entry[6:0];
    assign emit_data = entry[7:0];

    always_comb begin
        state_next      = state_reg;
        idx_next        = idx_reg;
        data_ptr_next   = data_ptr_reg;
        addr_ptr_next   = addr_ptr_reg;
        cur_addr_next   = cur_addr_reg;
        start_flag_next = start_flag_reg;
        emit            = EMIT_NONE;
        use_cur         = 1'b0;

        // whole FSM freezes until both output registers drain
        if (!pending) begin
            if (state_reg == SEQ_IDLE) begin
                // wait for a fresh start level
                if (start && !start_flag_reg) begin
                    idx_next        = '0;
                    start_flag_next = 1'b1;
                    state_next      = SEQ_RUN;
                end
            end else if (entry == OP_END) begin
                // end of list, close the bus and stop
                emit       = EMIT_STOP;
                state_next = SEQ_IDLE;
            end else if (entry == OP_DATA_BLOCK) begin
                // new data block from any mode
                data_ptr_next = idx_inc;
                idx_next      = idx_inc;
                state_next    = SEQ_FIND_ADDR_BLOCK;
            end else if (entry == OP_EXIT_MULTI) begin
                // back to plain single-device mode
                idx_next   = idx_inc;
                state_next = SEQ_RUN;
            end else begin
                // anything not matched below is skipped
                idx_next = idx_inc;
                case (state_reg)
                    SEQ_RUN, SEQ_DATA_BLOCK: begin
                        if (entry[8]) begin
                            emit = EMIT_WRITE;
                        end else if (entry[8:7] == 2'b01) begin
                            emit = EMIT_ADDR;
                        end else if (entry == OP_SEND_STOP) begin
                            emit = EMIT_STOP;
                        end else if (state_reg == SEQ_DATA_BLOCK &&
                                     entry == OP_WRITE_CUR) begin
                            emit    = EMIT_ADDR;
                            use_cur = 1'b1;
                        end else if (state_reg == SEQ_DATA_BLOCK &&
                                     entry == OP_ADDR_BLOCK) begin
                            // end of this pass, fetch the next address
                            idx_next   = addr_ptr_reg;
                            state_next = SEQ_NEXT_ADDR;
                        end
                    end
                    SEQ_FIND_ADDR_BLOCK: begin
                        // skip ahead over the data block
                        if (entry == OP_ADDR_BLOCK) begin
                            addr_ptr_next = idx_inc;
                            state_next    = SEQ_NEXT_ADDR;
                        end
                    end
                    SEQ_NEXT_ADDR: begin
                        // latch address, then replay the data block for it
                        if (entry[8:7] == 2'b01) begin
                            cur_addr_next = entry[6:0];
                            addr_ptr_next = idx_inc;
                            idx_next      = data_ptr_reg;
                            state_next    = SEQ_DATA_BLOCK;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg      <= SEQ_IDLE;
            idx_reg        <= '0;
            data_ptr_reg   <= '0;
            addr_ptr_reg   <= '0;
            cur_addr_reg   <= '0;
            start_flag_reg <= 1'b0;
            busy           <= 1'b0;
        end else begin
            state_reg    <= state_next;
            idx_reg      <= idx_next;
            data_ptr_reg <= data_ptr_next;
            addr_ptr_reg <= addr_ptr_next;
            cur_addr_reg <= cur_addr_next;
            // flag drops only once start goes low again
            start_flag_reg <= start && start_flag_next;
            busy           <= (state_reg != SEQ_IDLE);
        end
    end

    // a write or stop fills the output stage so nothing may follow next cycle
    assert property (@(posedge clk) disable iff (rst)
        (emit == EMIT_WRITE || emit == EMIT_STOP) |=> (emit == EMIT_NONE));

endmodule

`default_nettype wire

// File: source/init_table.mem
// one 9-bit table entry per line in hex, index 0 first, a note after the slashes
// 1dd writes byte dd, 0aa with bit 7 set starts a write to address aa & 7f
0D0 // start write to 0x50
1A5 // data a5
13C // data 3c
041 // send stop
002 // invalid entry, skipped
0A2 // start write to 0x22
101 // data 01
009 // data block start
003 // start write to current address
110 // data 10
1FF // data ff
041 // send stop
008 // address block start
0B0 // device 0x30
0B1 // device 0x31
0B2 // device 0x32
001 // exit multiple-device mode
0C8 // start write to 0x48
177 // data 77
000 // end of list
114 // past the end, a stray read would write its own index as data
115
116
117
118
119
11A
11B
11C
11D
11E
11F

// File: source/init_table_rom.sv
// command table storage for the init sequencer
// contents come from INIT_FILE at elaboration, read port has one cycle latency
// the sequencer presents the next index every cycle

`timescale 1ns/1ps
`default_nettype none

module init_table_rom
    import i2c_init_pkg::*;
(
    input  logic      clk,
    input  rom_addr_t rd_addr,
    output entry_t    entry
);

    entry_t mem [0:INIT_LEN-1];

    // read register powers up holding an end entry
    entry_t entry_reg = OP_END;

    initial begin
        $readmemh(INIT_FILE, mem);
    end

    always_ff @(posedge clk) begin
        entry_reg <= mem[rd_addr];
    end

    assign entry = entry_reg;

endmodule

`default_nettype wire
